// File: mempool_lite_pkg.sv
// Shared types, address map and register offsets of the memory system
// All widths assume a 32-bit byte address and a 32-bit data word
`default_nettype none

package mempool_lite_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  // Single-word host request
  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
    strb_t be;
  } mem_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    TgtL2,
    TgtBootrom,
    TgtCtrl,
    TgtNone
  } soc_target_e;

  // Address map, end addresses of ROM inclusive and of ctrl exclusive
  localparam addr_t L2BaseAddr      = 32'h8000_0000;
  localparam addr_t BootromBaseAddr = 32'hA000_0000;
  localparam addr_t BootromEndAddr  = 32'hA000_FFFF;
  localparam addr_t CtrlBaseAddr    = 32'h4000_0000;
  localparam addr_t CtrlEndAddr     = 32'h4001_0000;

  localparam int          BootromWords = 16;
  localparam logic [15:0] BootromTag   = 16'hB007;

  // Control register byte offsets
  localparam logic [7:0] RegEoc      = 8'h00;
  localparam logic [7:0] RegWakeUp   = 8'h04;
  localparam logic [7:0] RegNumCores = 8'h08;
  localparam logic [7:0] RegScratch0 = 8'h10;

  localparam data_t WakeAll = 32'hFFFF_FFFF;

endpackage : mempool_lite_pkg

`default_nettype wire

// File: l2_bank.sv
// Single-port SRAM bank, contents are not initialized
`timescale 1ns/1ps
`default_nettype none

module l2_bank #(
  parameter int unsigned L2BankWords = 64
) (
  input  logic                           clk_i,
  input  logic                           sel_i,
  input  logic                           we_i,
  input  logic [$clog2(L2BankWords)-1:0] row_i,
  input  mempool_lite_pkg::data_t        wdata_i,
  input  mempool_lite_pkg::strb_t        be_i,
  output mempool_lite_pkg::data_t        rdata_o
);

  mempool_lite_pkg::data_t mem_q [L2BankWords];

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (we_i) begin
        // Only enabled bytes are touched
        for (int b = 0; b < 4; b++) begin
          if (be_i[b]) begin
            mem_q[row_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[row_i];
      end
    end
  end

endmodule : l2_bank

`default_nettype wire

// File: l2_banked_mem.sv
// Word-interleaved L2 scratchpad, low word-index bits pick the bank
// NumL2Banks must be a power of two of at least 2, L2BankWords a power of two
`timescale 1ns/1ps
`default_nettype none

module l2_banked_mem #(
  parameter int unsigned NumL2Banks  = 4,
  parameter int unsigned L2BankWords = 64
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       valid_i,
  input  mempool_lite_pkg::mem_req_t req_i,
  output logic                       rvalid_o,
  output mempool_lite_pkg::data_t    rdata_o
);

  localparam int unsigned BankBits = $clog2(NumL2Banks);
  localparam int unsigned RowBits  = $clog2(L2BankWords);

  typedef logic [BankBits-1:0] bank_idx_t;
  typedef logic [RowBits-1:0]  row_idx_t;

  mempool_lite_pkg::addr_t offset;
  logic [29:0]             word_idx;
  bank_idx_t               bank;
  bank_idx_t               bank_q;
  row_idx_t                row;
  mempool_lite_pkg::data_t bank_rdata [NumL2Banks];

  assign offset   = req_i.addr - mempool_lite_pkg::L2BaseAddr;
  assign word_idx = offset[31:2];
  assign bank     = word_idx[BankBits-1:0];
  assign row      = word_idx[BankBits +: RowBits];

  for (genvar i = 0; i < NumL2Banks; i++) begin : gen_banks
    l2_bank #(
      .L2BankWords(L2BankWords)
    ) i_l2_bank (
      .clk_i  (clk_i                                 ),
      .sel_i  (valid_i && (bank == bank_idx_t'(i))   ),
      .we_i   (req_i.we                              ),
      .row_i  (row                                   ),
      .wdata_i(req_i.wdata                           ),
      .be_i   (req_i.be                              ),
      .rdata_o(bank_rdata[i]                         )
    );
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= valid_i;
    end
  end

  // Remember which bank answers next cycle
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      bank_q <= bank;
    end
  end

  assign rdata_o = bank_rdata[bank_q];

endmodule : l2_banked_mem

`default_nettype wire

// File: bootrom.sv
// Boot ROM, word i holds BootromTag in the upper half and i in the lower half
// Words past BootromWords read as zero
`timescale 1ns/1ps
`default_nettype none

module bootrom (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    valid_i,
  input  mempool_lite_pkg::addr_t addr_i,
  output logic                    rvalid_o,
  output mempool_lite_pkg::data_t rdata_o
);

  localparam int IdxBits = $clog2(mempool_lite_pkg::BootromWords);

  mempool_lite_pkg::addr_t offset;
  logic [29:0]             word_idx;
  mempool_lite_pkg::data_t rom_table [mempool_lite_pkg::BootromWords];

  for (genvar i = 0; i < mempool_lite_pkg::BootromWords; i++) begin : gen_table
    assign rom_table[i] = {mempool_lite_pkg::BootromTag, 16'(i)};
  end

  assign offset   = addr_i - mempool_lite_pkg::BootromBaseAddr;
  assign word_idx = offset[31:2];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      if (word_idx < 30'(mempool_lite_pkg::BootromWords)) begin
        rdata_o <= rom_table[word_idx[IdxBits-1:0]];
      end else begin
        rdata_o <= '0;
      end
    end
  end

endmodule : bootrom

`default_nettype wire

// File: ctrl_registers.sv
// EOC, wake-up, core count and four scratch words, 16-bit offset window
// Scratch words are not cleared by reset
`timescale 1ns/1ps
`default_nettype none

module ctrl_registers #(
  parameter int unsigned NumCores = 8
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       valid_i,
  input  mempool_lite_pkg::mem_req_t req_i,
  output logic                       rvalid_o,
  output mempool_lite_pkg::mem_rsp_t rsp_o,
  output logic [NumCores-1:0]        wake_up_o,
  output mempool_lite_pkg::data_t    eoc_o,
  output logic                       eoc_valid_o
);

  typedef logic [NumCores-1:0] core_mask_t;

  logic [7:0]              offset;
  logic                    reg_hit;
  logic                    is_scratch;
  mempool_lite_pkg::data_t rd_value;
  mempool_lite_pkg::data_t eoc_q;
  core_mask_t              wake_q;
  mempool_lite_pkg::data_t scratch_q [4];

  function automatic mempool_lite_pkg::data_t apply_be(mempool_lite_pkg::data_t old_val,
                                                       mempool_lite_pkg::data_t new_val,
                                                       mempool_lite_pkg::strb_t be);
    mempool_lite_pkg::data_t res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign offset     = req_i.addr[7:0];
  assign is_scratch = (offset[7:4] == mempool_lite_pkg::RegScratch0[7:4]) &&
                      (offset[1:0] == 2'b00);

  // Read mux and offset check
  always_comb begin
    reg_hit  = 1'b1;
    rd_value = '0;
    case (offset)
      mempool_lite_pkg::RegEoc:      rd_value = eoc_q;
      mempool_lite_pkg::RegWakeUp:   rd_value = '0;
      mempool_lite_pkg::RegNumCores: rd_value = mempool_lite_pkg::data_t'(NumCores);
      default: begin
        if (is_scratch) begin
          rd_value = scratch_q[offset[3:2]];
        end else begin
          reg_hit = 1'b0;
        end
      end
    endcase
    if (req_i.addr[15:8] != 8'h00) begin
      reg_hit = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      eoc_q    <= '0;
      wake_q   <= '0;
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= valid_i;
      // Wake-up is a single-cycle pulse
      wake_q   <= '0;
      if (valid_i && req_i.we && reg_hit) begin
        if (offset == mempool_lite_pkg::RegEoc) begin
          eoc_q <= apply_be(eoc_q, req_i.wdata, req_i.be);
        end else if (offset == mempool_lite_pkg::RegWakeUp) begin
          if (req_i.wdata == mempool_lite_pkg::WakeAll) begin
            wake_q <= '1;
          end else begin
            wake_q <= core_mask_t'(1) << (req_i.wdata % NumCores);
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && req_i.we && reg_hit && is_scratch) begin
      scratch_q[offset[3:2]] <= apply_be(scratch_q[offset[3:2]], req_i.wdata, req_i.be);
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rsp_o.rdata <= rd_value;
      rsp_o.err   <= !reg_hit;
    end
  end

  assign wake_up_o   = wake_q;
  assign eoc_o       = eoc_q;
  assign eoc_valid_o = eoc_q[0];

endmodule : ctrl_registers

`default_nettype wire

// File: soc_addr_decoder.sv
// Routes each host request to L2, boot ROM or ctrl registers by address
// Unmapped addresses and boot ROM writes are answered here with err set
`timescale 1ns/1ps
`default_nettype none

module soc_addr_decoder #(
  parameter int unsigned NumL2Banks  = 4,
  parameter int unsigned L2BankWords = 64
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       req_valid_i,
  input  mempool_lite_pkg::mem_req_t req_i,
  output logic                       rsp_valid_o,
  output mempool_lite_pkg::mem_rsp_t rsp_o,
  output logic                       l2_valid_o,
  output logic                       rom_valid_o,
  output logic                       ctrl_valid_o,
  input  logic                       l2_rvalid_i,
  input  logic                       rom_rvalid_i,
  input  logic                       ctrl_rvalid_i,
  input  mempool_lite_pkg::data_t    l2_rdata_i,
  input  mempool_lite_pkg::data_t    rom_rdata_i,
  input  mempool_lite_pkg::mem_rsp_t ctrl_rsp_i
);

  localparam mempool_lite_pkg::addr_t L2Size =
    mempool_lite_pkg::addr_t'(NumL2Banks * L2BankWords * 4);
  localparam mempool_lite_pkg::addr_t L2EndAddr = mempool_lite_pkg::L2BaseAddr + L2Size;

  mempool_lite_pkg::soc_target_e tgt;
  mempool_lite_pkg::soc_target_e tgt_q;
  logic                          dec_err;
  logic                          err_q;

  // Address map lookup, anything outside the windows falls to TgtNone
  always_comb begin
    tgt = mempool_lite_pkg::TgtNone;
    if (req_i.addr >= mempool_lite_pkg::L2BaseAddr && req_i.addr < L2EndAddr) begin
      tgt = mempool_lite_pkg::TgtL2;
    end else if (req_i.addr >= mempool_lite_pkg::BootromBaseAddr &&
                 req_i.addr <= mempool_lite_pkg::BootromEndAddr) begin
      tgt = mempool_lite_pkg::TgtBootrom;
    end else if (req_i.addr >= mempool_lite_pkg::CtrlBaseAddr &&
                 req_i.addr < mempool_lite_pkg::CtrlEndAddr) begin
      tgt = mempool_lite_pkg::TgtCtrl;
    end
  end

  assign dec_err = (tgt == mempool_lite_pkg::TgtNone) ||
                   (tgt == mempool_lite_pkg::TgtBootrom && req_i.we);

  assign l2_valid_o   = req_valid_i && (tgt == mempool_lite_pkg::TgtL2);
  // A write to the ROM never reaches it
  assign rom_valid_o  = req_valid_i && (tgt == mempool_lite_pkg::TgtBootrom) && !req_i.we;
  assign ctrl_valid_o = req_valid_i && (tgt == mempool_lite_pkg::TgtCtrl);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tgt_q <= mempool_lite_pkg::TgtNone;
      err_q <= 1'b0;
    end else begin
      tgt_q <= tgt;
      err_q <= req_valid_i && dec_err;
    end
  end

  // Targets answer with a one-cycle read-valid, errors come from err_q
  assign rsp_valid_o = l2_rvalid_i || rom_rvalid_i || ctrl_rvalid_i || err_q;

  always_comb begin
    rsp_o = '0;
    if (err_q) begin
      rsp_o.err = 1'b1;
    end else begin
      case (tgt_q)
        mempool_lite_pkg::TgtL2:      rsp_o.rdata = l2_rdata_i;
        mempool_lite_pkg::TgtBootrom: rsp_o.rdata = rom_rdata_i;
        mempool_lite_pkg::TgtCtrl:    rsp_o = ctrl_rsp_i;
        default:                      rsp_o = '0;
      endcase
    end
  end

endmodule : soc_addr_decoder

`default_nettype wire

// File: mempool_lite_system.sv
// Memory system top: host port, address decoder, banked L2, boot ROM and ctrl registers
// Every request is accepted when presented, its response follows one cycle later
`timescale 1ns/1ps
`default_nettype none

module mempool_lite_system #(
  parameter int unsigned NumL2Banks  = 4,
  parameter int unsigned L2BankWords = 64,
  parameter int unsigned NumCores    = 8
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       req_valid_i,
  input  mempool_lite_pkg::mem_req_t req_i,
  output logic                       rsp_valid_o,
  output mempool_lite_pkg::mem_rsp_t rsp_o,
  output logic [NumCores-1:0]        wake_up_o,
  output logic                       eoc_valid_o,
  output mempool_lite_pkg::data_t    eoc_o
);

  logic                       l2_valid;
  logic                       rom_valid;
  logic                       ctrl_valid;
  logic                       l2_rvalid;
  logic                       rom_rvalid;
  logic                       ctrl_rvalid;
  mempool_lite_pkg::data_t    l2_rdata;
  mempool_lite_pkg::data_t    rom_rdata;
  mempool_lite_pkg::mem_rsp_t ctrl_rsp;

  soc_addr_decoder #(
    .NumL2Banks (NumL2Banks ),
    .L2BankWords(L2BankWords)
  ) i_soc_addr_decoder (
    .clk_i        (clk_i      ),
    .rst_i        (rst_i      ),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i      ),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o      ),
    .l2_valid_o   (l2_valid   ),
    .rom_valid_o  (rom_valid  ),
    .ctrl_valid_o (ctrl_valid ),
    .l2_rvalid_i  (l2_rvalid  ),
    .rom_rvalid_i (rom_rvalid ),
    .ctrl_rvalid_i(ctrl_rvalid),
    .l2_rdata_i   (l2_rdata   ),
    .rom_rdata_i  (rom_rdata  ),
    .ctrl_rsp_i   (ctrl_rsp   )
  );

  l2_banked_mem #(
    .NumL2Banks (NumL2Banks ),
    .L2BankWords(L2BankWords)
  ) i_l2_banked_mem (
    .clk_i   (clk_i    ),
    .rst_i   (rst_i    ),
    .valid_i (l2_valid ),
    .req_i   (req_i    ),
    .rvalid_o(l2_rvalid),
    .rdata_o (l2_rdata )
  );

  bootrom i_bootrom (
    .clk_i   (clk_i     ),
    .rst_i   (rst_i     ),
    .valid_i (rom_valid ),
    .addr_i  (req_i.addr),
    .rvalid_o(rom_rvalid),
    .rdata_o (rom_rdata )
  );

  ctrl_registers #(
    .NumCores(NumCores)
  ) i_ctrl_registers (
    .clk_i      (clk_i      ),
    .rst_i      (rst_i      ),
    .valid_i    (ctrl_valid ),
    .req_i      (req_i      ),
    .rvalid_o   (ctrl_rvalid),
    .rsp_o      (ctrl_rsp   ),
    .wake_up_o  (wake_up_o  ),
    .eoc_o      (eoc_o      ),
    .eoc_valid_o(eoc_valid_o)
  );

endmodule : mempool_lite_system

`default_nettype wire

// File: tb_mempool_lite_system.sv
// Plays mempool_lite_stim.txt against the default configuration of the memory system
// The EOC and wake-up outputs are checked every cycle against a small register model
`timescale 1ns/1ps
`default_nettype none

module tb_mempool_lite_system;

  localparam int NumCores   = 8;
  localparam int Fields     = 7;
  localparam int MaxLines   = 64;
  localparam int RspTimeout = 20;

  localparam mempool_lite_pkg::addr_t EocAddr  = 32'h4000_0000;
  localparam mempool_lite_pkg::addr_t WakeAddr = 32'h4000_0004;

  typedef logic [NumCores-1:0] core_mask_t;

  logic                       clk_i;
  logic                       rst_i;
  logic                       req_valid_i;
  mempool_lite_pkg::mem_req_t req_i;
  logic                       rsp_valid_o;
  mempool_lite_pkg::mem_rsp_t rsp_o;
  core_mask_t                 wake_up_o;
  logic                       eoc_valid_o;
  mempool_lite_pkg::data_t    eoc_o;

  logic [31:0] stim [Fields*MaxLines];
  int          errors;
  int          timeouts;
  int          cur_line;
  logic        mon_en;

  // Outstanding accesses with their stim line and issue cycle
  int                         exp_line_q [$];
  int                         exp_cycle_q [$];
  int                         cycle_cnt;
  logic                       prev_valid;
  mempool_lite_pkg::mem_req_t prev_req;
  mempool_lite_pkg::data_t    exp_eoc;
  core_mask_t                 exp_wake;

  mempool_lite_system DUT (
    .clk_i      (clk_i      ),
    .rst_i      (rst_i      ),
    .req_valid_i(req_valid_i),
    .req_i      (req_i      ),
    .rsp_valid_o(rsp_valid_o),
    .rsp_o      (rsp_o      ),
    .wake_up_o  (wake_up_o  ),
    .eoc_valid_o(eoc_valid_o),
    .eoc_o      (eoc_o      )
  );

  always #5 clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Byte lanes enabled by be take the new value
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0]  be);
    logic [31:0] lane_mask;
    lane_mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_val & ~lane_mask) | (new_val & lane_mask);
  endfunction

  // One core per write or every core for the broadcast value
  function automatic core_mask_t wake_mask(input logic [31:0] wdata);
    core_mask_t mask;
    for (int c = 0; c < NumCores; c++) begin
      mask[c] = (wdata == mempool_lite_pkg::WakeAll) || (wdata % 32'(NumCores) == 32'(c));
    end
    return mask;
  endfunction

  task automatic check_response();
    int    line_idx;
    int    issued;
    string tag;
    if (exp_line_q.size() == 0) begin
      errors++;
      $display("a response arrived in cycle %0d with no request outstanding", cycle_cnt);
    end else begin
      line_idx = exp_line_q.pop_front();
      issued   = exp_cycle_q.pop_front();
      tag      = $sformatf("access %0d", line_idx + 1);
      check_value({tag, " response cycle"}, 32'(issued + 1), 32'(cycle_cnt));
      check_value({tag, " err"}, stim[line_idx*Fields+6], 32'(rsp_o.err));
      if (stim[line_idx*Fields+4][0]) begin
        check_value({tag, " rdata"}, stim[line_idx*Fields+5], rsp_o.rdata);
      end
    end
  endtask

  // Sampled mid-cycle away from the edge where inputs change
  always @(negedge clk_i) begin
    if (mon_en) begin
      exp_wake = '0;
      if (prev_valid && prev_req.we && prev_req.addr == EocAddr) begin
        exp_eoc = merge_bytes(exp_eoc, prev_req.wdata, prev_req.be);
      end
      if (prev_valid && prev_req.we && prev_req.addr == WakeAddr) begin
        exp_wake = wake_mask(prev_req.wdata);
      end
      check_value($sformatf("wake_up_o cycle %0d", cycle_cnt), 32'(exp_wake), 32'(wake_up_o));
      check_value($sformatf("eoc_o cycle %0d", cycle_cnt), exp_eoc, eoc_o);
      check_value($sformatf("eoc_valid_o cycle %0d", cycle_cnt), 32'(exp_eoc[0]),
                  32'(eoc_valid_o));
      if (rsp_valid_o) begin
        check_response();
      end else if (prev_valid) begin
        errors++;
        $display("no response in cycle %0d for the request of the previous cycle", cycle_cnt);
      end
      prev_valid = req_valid_i;
      prev_req   = req_i;
      if (req_valid_i) begin
        exp_line_q.push_back(cur_line);
        exp_cycle_q.push_back(cycle_cnt);
      end
      cycle_cnt++;
    end
  end

  initial begin
    int idx;
    int waited;
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    cur_line    = 0;
    mon_en      = 1'b0;
    errors      = 0;
    timeouts    = 0;
    cycle_cnt   = 0;
    prev_valid  = 1'b0;
    prev_req    = '0;
    exp_eoc     = '0;
    exp_wake    = '0;
    $readmemh("mempool_lite_stim.txt", stim);

    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_value("reset rsp_valid_o", 32'h0, 32'(rsp_valid_o));
    check_value("reset wake_up_o", 32'h0, 32'(wake_up_o));
    check_value("reset eoc_valid_o", 32'h0, 32'(eoc_valid_o));
    check_value("reset eoc_o", 32'h0, eoc_o);

    @(posedge clk_i);
    mon_en <= 1'b1;
    // One access per cycle until the end marker
    idx = 0;
    while (idx < MaxLines && stim[idx*Fields] != 32'hF) begin
      req_valid_i <= 1'b1;
      req_i.we    <= stim[idx*Fields][0];
      req_i.addr  <= stim[idx*Fields+1];
      req_i.wdata <= stim[idx*Fields+2];
      req_i.be    <= stim[idx*Fields+3][3:0];
      cur_line    <= idx;
      idx++;
      @(posedge clk_i);
    end
    req_valid_i <= 1'b0;
    req_i       <= '0;

    waited = 0;
    while (exp_line_q.size() != 0 && waited < RspTimeout) begin
      @(posedge clk_i);
      waited++;
    end
    if (exp_line_q.size() != 0) begin
      timeouts++;
      $display("timeout: %0d responses still missing after %0d cycles",
               exp_line_q.size(), RspTimeout);
    end
    // Side outputs of the last access settle one cycle later
    repeat (2) @(posedge clk_i);

    $display("%0d accesses played, %0d errors, %0d timeouts", idx, errors, timeouts);
    if (errors == 0 && timeouts == 0 && idx > 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule : tb_mempool_lite_system

`default_nettype wire

// File: mempool_lite_stim.txt
// we addr wdata be check_rdata exp_rdata exp_err, all hex, one access per line
// A line with we = f ends the stimulus
0 40000008 00000000 0 1 00000008 0
1 80000000 11111111 f 0 00000000 0
1 80000004 22222222 f 0 00000000 0
1 80000008 33333333 f 0 00000000 0
1 8000000c 44444444 f 0 00000000 0
1 800003fc cafef00d f 0 00000000 0
0 80000000 00000000 0 1 11111111 0
0 80000004 00000000 0 1 22222222 0
0 80000008 00000000 0 1 33333333 0
0 8000000c 00000000 0 1 44444444 0
0 800003fc 00000000 0 1 cafef00d 0
1 80000004 aabbccdd 5 0 00000000 0
0 80000004 00000000 0 1 22bb22dd 0
0 a0000000 00000000 0 1 b0070000 0
0 a000003c 00000000 0 1 b007000f 0
0 a0000040 00000000 0 1 00000000 0
1 a0000000 12345678 f 1 00000000 1
0 00001000 00000000 0 1 00000000 1
0 80000400 00000000 0 1 00000000 1
0 4000000c 00000000 0 0 00000000 1
0 40000100 00000000 0 0 00000000 1
1 40000000 00000029 f 0 00000000 0
1 40000000 0000ff00 2 0 00000000 0
0 40000000 00000000 0 1 0000ff29 0
1 40000010 deadbeef f 0 00000000 0
1 4000001c 0badc0de f 0 00000000 0
0 40000010 00000000 0 1 deadbeef 0
0 4000001c 00000000 0 1 0badc0de 0
1 40000004 00000003 f 0 00000000 0
0 40000004 00000000 0 1 00000000 0
1 40000004 ffffffff f 0 00000000 0
1 40000008 00000005 f 0 00000000 0
0 40000008 00000000 0 1 00000008 0
f 00000000 00000000 0 0 00000000 0

// File: compile.f
mempool_lite_pkg.sv
l2_bank.sv
l2_banked_mem.sv
bootrom.sv
ctrl_registers.sv
soc_addr_decoder.sv
mempool_lite_system.sv
tb_mempool_lite_system.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       ?= tb_mempool_lite_system
RTL_TOP   ?= mempool_lite_system
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary -j 0 $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
